// File: tpu_weights.f
source/tpu_package.sv
source/handshake_fifo.sv
source/weight_control_unit.sv
source/weight_stage.sv
source/dot_product_unit.sv
source/tpu_weights_top.sv
tb/tpu_weights_props.sv
tb/tpu_weights_tb.sv

// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
TB_TOP     := tpu_weights_tb
RTL_TOP    := tpu_weights_top
FILE_LIST  := tpu_weights.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tpu_weights_tb.sv
`timescale 1ns/1ps

module tpu_weights_tb
    import tpu_package::*;
();

    localparam int NUM_TILES = 10;

    logic                            clk_i = 1'b0;
    logic                            rst_n_i;
    logic                            weight_req_i;
    weight_t                         weight_data_i;
    logic                            weight_ack_o;
    logic                            act_req_i;
    logic [MUL_SIZE-1:0][DATA_W-1:0] act_data_i;
    logic                            act_last_i;
    logic                            act_ack_o;
    logic                            res_req_o;
    logic [ACC_W-1:0]                res_data_o;
    logic                            res_ack_i;

    logic [31:0]                     rng_state = 32'heb49_0db3;
    logic [MUL_SIZE-1:0][DATA_W-1:0] tile_w [NUM_TILES];
    int                              w_gap [NUM_TILES*MUL_SIZE];
    logic [MUL_SIZE-1:0][DATA_W-1:0] vec_lanes [$];
    logic                            vec_last [$];
    int                              act_gap [$];
    int                              ack_delay [$];
    logic [ACC_W-1:0]                exp_sum [$];   // Model results in send order
    int                              exp_tile [$];

    int               total_vectors;
    int               results_seen;
    int               weights_taken;
    int               wait_cycles;
    bit               stall_seen;
    bit               run_started;
    logic             req_prev;
    logic [ACC_W-1:0] data_prev;
    logic [ACC_W-1:0] exp_value;
    int               exp_t;

    tpu_weights_top uut (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_range(int lo, int hi);
        return lo + int'(next_rand() % 32'(hi - lo + 1));
    endfunction

    // Extremes on a quarter of the draws
    function automatic logic [DATA_W-1:0] pick_lane();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return 8'h80;
            3'd1:    return 8'h7f;
            default: return r[15:8];
        endcase
    endfunction

    function automatic logic [ACC_W-1:0] dot_model(
        input logic [MUL_SIZE-1:0][DATA_W-1:0] lanes,
        input logic [MUL_SIZE-1:0][DATA_W-1:0] weights
    );
        int acc;
        int a;
        int w;
        acc = 0;
        for (int i = 0; i < MUL_SIZE; i++) begin
            a   = $signed(lanes[i]);
            w   = $signed(weights[i]);
            acc = acc + a * w;
        end
        return ACC_W'(acc);
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ========================================
    // Stimulus and model
    // ========================================
    task automatic build_stimulus();
        int                              n_vec;
        logic [MUL_SIZE-1:0][DATA_W-1:0] lanes;
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int l = 0; l < MUL_SIZE; l++) begin
                tile_w[t][l]          = pick_lane();
                w_gap[t*MUL_SIZE + l] = (t < 3) ? rand_range(5, 15) : 0;  // Slow, then burst
            end
            n_vec = (t == 0) ? 5 : (t >= 3 && t <= 6) ? rand_range(3, 5) : rand_range(1, 4);
            for (int v = 0; v < n_vec; v++) begin
                for (int l = 0; l < MUL_SIZE; l++) begin
                    lanes[l] = pick_lane();
                end
                vec_lanes.push_back(lanes);
                vec_last.push_back(v == n_vec - 1);
                if (t >= 3 && t <= 6) begin
                    act_gap.push_back(rand_range(20, 40));   // Lets weights run two tiles ahead
                end else begin
                    act_gap.push_back(rand_range(0, 3));
                end
                if (next_rand() % 4 == 0) begin
                    ack_delay.push_back(rand_range(10, 40));
                end else begin
                    ack_delay.push_back(rand_range(0, 3));
                end
                exp_sum.push_back(dot_model(lanes, tile_w[t]));
                exp_tile.push_back(t);
            end
        end
        total_vectors = vec_lanes.size();
    endtask

    task automatic send_weight(input logic [DATA_W-1:0] value);
        weight_data_i <= value;
        weight_req_i  <= 1'b1;
        do begin
            @(posedge clk_i);
        end while (!weight_ack_o);
        weights_taken++;
        weight_req_i <= 1'b0;
        do begin
            @(posedge clk_i);
        end while (weight_ack_o);
    endtask

    task automatic send_vector(input logic [MUL_SIZE-1:0][DATA_W-1:0] lanes, input logic last);
        act_data_i <= lanes;
        act_last_i <= last;
        act_req_i  <= 1'b1;
        do begin
            @(posedge clk_i);
        end while (!act_ack_o);
        act_req_i <= 1'b0;
        do begin
            @(posedge clk_i);
        end while (act_ack_o);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        rst_n_i       = 1'b0;
        weight_req_i  = 1'b0;
        weight_data_i = '0;
        act_req_i     = 1'b0;
        act_data_i    = '0;
        act_last_i    = 1'b0;
        res_ack_i     = 1'b0;
        results_seen  = 0;
        weights_taken = 0;
        wait_cycles   = 0;
        build_stimulus();
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        assert (!weight_ack_o && !act_ack_o && !res_req_o)
            else abort_run("Handshake outputs are not low after reset");
        run_started = 1'b1;
        wait (results_seen == total_vectors);
        repeat (20) @(posedge clk_i);
        assert (stall_seen) else abort_run("Weight link never saw back-pressure");
        if (exp_sum.size() == 0 && !res_req_o) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("Results are left over at the end of the run");
        end
    end

    initial begin
        wait (run_started);
        repeat (40) @(posedge clk_i);   // Vectors queue up before any weight
        for (int i = 0; i < NUM_TILES*MUL_SIZE; i++) begin
            repeat (w_gap[i]) @(posedge clk_i);
            send_weight(tile_w[i / MUL_SIZE][i % MUL_SIZE]);
        end
    end

    initial begin
        wait (run_started);
        @(posedge clk_i);
        for (int i = 0; i < total_vectors; i++) begin
            repeat (act_gap[i]) @(posedge clk_i);
            send_vector(vec_lanes[i], vec_last[i]);
        end
    end

    // Result responder
    initial begin
        int idx;
        idx = 0;
        wait (run_started);
        forever begin
            @(posedge clk_i);
            if (res_req_o && !res_ack_i) begin
                repeat (ack_delay[idx]) @(posedge clk_i);
                idx++;
                res_ack_i <= 1'b1;
                do begin
                    @(posedge clk_i);
                end while (res_req_o);
                @(posedge clk_i);   // Ack held a cycle past the falling req
                res_ack_i <= 1'b0;
            end
        end
    end

    initial begin
        wait (run_started);
        repeat (200 * total_vectors + 2000) @(posedge clk_i);
        abort_run("Timeout: not every expected result arrived in time");
    end

    // ========================================
    // Result monitor
    // ========================================
    always @(negedge clk_i) begin
        if (run_started) begin
            if (res_req_o && !req_prev) begin
                assert (!res_ack_i) else abort_run("Result request rose while ack was high");
                assert (exp_sum.size() != 0) else abort_run("Result with no vector outstanding");
                exp_value = exp_sum.pop_front();
                exp_t     = exp_tile.pop_front();
                assert (weights_taken >= MUL_SIZE * (exp_t + 1))
                    else abort_run("Result appeared before its weight tile was complete");
                assert (res_data_o == exp_value)
                    else abort_run($sformatf(
                        "error: dot_product tile %0d result %0d expected %0d actual %0d",
                        exp_t, results_seen, $signed(exp_value), $signed(res_data_o)));
                results_seen++;
            end
            if (res_req_o && req_prev) begin
                assert (res_data_o == data_prev)
                    else abort_run("Result data changed during request");
            end
            if (!res_req_o && req_prev) begin
                assert (res_ack_i) else abort_run("Result request fell without an ack");
            end
            if (weight_req_i && !weight_ack_o) begin
                wait_cycles++;
                if (wait_cycles >= 2) stall_seen = 1'b1;   // Queue and both banks full
            end else begin
                wait_cycles = 0;
            end
        end
        req_prev  = res_req_o;
        data_prev = res_data_o;
    end

endmodule

// File: tb/tpu_weights_props.sv
`timescale 1ns/1ps

module tpu_weights_props
    import tpu_package::*;
(
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                next_tile_i,
    input logic                rdy_i,
    input logic                buffered_i,
    input logic [MUL_SIZE-1:0] load_weights_i,
    input weight_state_t       state_i
);

    // ========================================
    // Weight control properties
    // ========================================
    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(load_weights_i))
        else $error("More than one bank lane written in one cycle");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(state_i inside {LOAD_WEIGHTS, DOUBLE_BUFFER}) |-> (load_weights_i == '0))
        else $error("Bank lane written outside the loading states");

    assert property (@(posedge clk_i) disable iff (!rst_n_i) buffered_i |-> rdy_i)
        else $error("Shadow bank full while the active bank is not ready");

    // FULL is left only when a tile retires
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == FULL && !next_tile_i) |=> (state_i == FULL))
        else $error("Weight state left FULL without a tile retirement");

endmodule

bind weight_control_unit tpu_weights_props u_props (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .next_tile_i    (next_weight_tile_i),
    .rdy_i          (compute_weights_rdy_o),
    .buffered_i     (compute_weights_buffered_o),
    .load_weights_i (load_weights_o),
    .state_i        (weight_state_q)
);

// File: source/tpu_weights_top.sv
`timescale 1ns/1ps

module tpu_weights_top
    import tpu_package::*;
(
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic                            weight_req_i,
    input  weight_t                         weight_data_i,
    output logic                            weight_ack_o,

    input  logic                            act_req_i,
    input  logic [MUL_SIZE-1:0][DATA_W-1:0] act_data_i,
    input  logic                            act_last_i,
    output logic                            act_ack_o,

    output logic                            res_req_o,
    output logic [ACC_W-1:0]                res_data_o,
    input  logic                            res_ack_i
);

    logic                   compute_weights_rdy;
    logic                   next_weight_tile;
    weight_t [MUL_SIZE-1:0] active_weights;

    act_vec_t               act_in;
    act_vec_t               act_head;
    logic                   act_valid;
    logic                   act_pop;

    assign act_in.last  = act_last_i;
    assign act_in.lanes = act_data_i;

    weight_stage u_weight_stage (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .weight_req_i          (weight_req_i),
        .weight_data_i         (weight_data_i),
        .weight_ack_o          (weight_ack_o),
        .next_weight_tile_i    (next_weight_tile),
        .compute_weights_rdy_o (compute_weights_rdy),
        .active_weights_o      (active_weights)
    );

    handshake_fifo #(
        .T (act_vec_t)
    ) u_act_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (act_req_i),
        .data_i  (act_in),
        .ack_o   (act_ack_o),
        .pop_i   (act_pop),
        .valid_o (act_valid),
        .head_o  (act_head)
    );

    dot_product_unit u_dot_product (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .act_valid_i           (act_valid),
        .act_head_i            (act_head),
        .act_pop_o             (act_pop),
        .compute_weights_rdy_i (compute_weights_rdy),
        .active_weights_i      (active_weights),
        .next_weight_tile_o    (next_weight_tile),
        .res_req_o             (res_req_o),
        .res_data_o            (res_data_o),
        .res_ack_i             (res_ack_i)
    );

endmodule

// File: source/dot_product_unit.sv
`timescale 1ns/1ps

module dot_product_unit
    import tpu_package::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Activation queue
    input  logic                   act_valid_i,
    input  act_vec_t               act_head_i,
    output logic                   act_pop_o,

    // Weight stage
    input  logic                   compute_weights_rdy_i,
    input  weight_t [MUL_SIZE-1:0] active_weights_i,
    output logic                   next_weight_tile_o,

    // Result link
    output logic                   res_req_o,
    output logic [ACC_W-1:0]       res_data_o,
    input  logic                   res_ack_i
);

    logic                       s1_valid_q;
    logic signed [2*DATA_W-1:0] s1_prod_q [MUL_SIZE];

    logic                       s2_ready;
    logic                       s1_advance;
    logic                       s2_load;
    logic signed [ACC_W-1:0]    dot_sum;

    // ========================================
    // Stall chain
    // ========================================

    // Result register is free once req is down and the ack has fallen
    assign s2_ready   = !res_req_o && !res_ack_i;
    assign s2_load    = s1_valid_q && s2_ready;
    assign s1_advance = !s1_valid_q || s2_ready;

    assign act_pop_o          = act_valid_i && compute_weights_rdy_i && s1_advance;
    assign next_weight_tile_o = act_pop_o && act_head_i.last;   // Next vector sees new bank

    // ========================================
    // Stage 1, lane products
    // ========================================
    always_ff @(posedge clk_i) begin
        if (act_pop_o) begin
            for (int i = 0; i < MUL_SIZE; i++) begin
                s1_prod_q[i] <= $signed(act_head_i.lanes[i]) * $signed(active_weights_i[i]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
        end else if (s1_advance) begin
            s1_valid_q <= act_pop_o;
        end
    end

    // ========================================
    // Stage 2, sum and result sender
    // ========================================
    always_comb begin
        dot_sum = '0;
        for (int i = 0; i < MUL_SIZE; i++) begin
            dot_sum = dot_sum + ACC_W'(s1_prod_q[i]);   // Sign extended
        end
    end

    always_ff @(posedge clk_i) begin
        if (s2_load) begin
            res_data_o <= dot_sum;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_req_o <= 1'b0;
        end else if (s2_load) begin
            res_req_o <= 1'b1;              // Data is set in the same edge
        end else if (res_req_o && res_ack_i) begin
            res_req_o <= 1'b0;
        end
    end

endmodule

// File: source/weight_stage.sv
`timescale 1ns/1ps

module weight_stage
    import tpu_package::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   weight_req_i,
    input  weight_t                weight_data_i,
    output logic                   weight_ack_o,
    input  logic                   next_weight_tile_i,
    output logic                   compute_weights_rdy_o,
    output weight_t [MUL_SIZE-1:0] active_weights_o
);

    weight_t [MUL_SIZE-1:0] bank_q [2];
    logic                   bank_sel_q;    // Index of the active bank

    logic                   weight_valid;
    weight_t                weight_head;
    logic                   weight_pop;
    logic [MUL_SIZE-1:0]    lane_we;
    logic                   load_shadow;
    logic                   wr_bank;

    // ========================================
    // Weight queue and control
    // ========================================
    handshake_fifo #(
        .T (weight_t)
    ) u_weight_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (weight_req_i),
        .data_i  (weight_data_i),
        .ack_o   (weight_ack_o),
        .pop_i   (weight_pop),
        .valid_o (weight_valid),
        .head_o  (weight_head)
    );

    weight_control_unit u_weight_ctrl (
        .clk_i                      (clk_i),
        .rst_n_i                    (rst_n_i),
        .weight_fifo_valid_i        (weight_valid),
        .next_weight_tile_i         (next_weight_tile_i),
        .compute_weights_rdy_o      (compute_weights_rdy_o),
        .compute_weights_buffered_o (),
        .load_weights_o             (lane_we),
        .load_bank_shadow_o         (load_shadow)
    );

    assign weight_pop = |lane_we;                 // Only in the two loading states
    assign wr_bank    = bank_sel_q ^ load_shadow;

    // ========================================
    // Banks
    // ========================================
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < MUL_SIZE; i++) begin
            if (lane_we[i]) bank_q[wr_bank][i] <= weight_head;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bank_sel_q <= 1'b0;
        end else if (next_weight_tile_i) begin
            bank_sel_q <= ~bank_sel_q;    // Same edge as the control state change
        end
    end

    assign active_weights_o = bank_q[bank_sel_q];

endmodule

// File: source/weight_control_unit.sv
`timescale 1ns/1ps

module weight_control_unit
    import tpu_package::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                weight_fifo_valid_i,
    input  logic                next_weight_tile_i,
    output logic                compute_weights_rdy_o,
    output logic                compute_weights_buffered_o,
    output logic [MUL_SIZE-1:0] load_weights_o,
    output logic                load_bank_shadow_o
);

    weight_state_t     weight_state_q;
    logic [CNTR_W-1:0] load_weights_cntr_q;

    logic loading;
    logic lane_load;
    logic last_lane;
    logic tile_done;

    // ========================================
    // Lane strobes and status
    // ========================================
    assign loading   = (weight_state_q == LOAD_WEIGHTS) || (weight_state_q == DOUBLE_BUFFER);
    assign lane_load = loading && weight_fifo_valid_i;
    assign last_lane = (load_weights_cntr_q == CNTR_W'(MUL_SIZE - 1));
    assign tile_done = lane_load && last_lane;   // Bank being filled completes this edge

    // One lane written per popped weight
    assign load_weights_o = lane_load ? (MUL_SIZE'(1) << load_weights_cntr_q) : '0;

    assign load_bank_shadow_o = (weight_state_q == DOUBLE_BUFFER);

    // Active bank is complete once loading has moved on to the shadow
    assign compute_weights_rdy_o =
        (weight_state_q == DOUBLE_BUFFER) || (weight_state_q == FULL);

    assign compute_weights_buffered_o = (weight_state_q == FULL);

    // ========================================
    // Lane counter
    // ========================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_weights_cntr_q <= '0;
        end else if (lane_load) begin
            if (last_lane) begin
                load_weights_cntr_q <= '0;
            end else begin
                load_weights_cntr_q <= load_weights_cntr_q + 1'b1;
            end
        end
    end

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            weight_state_q <= IDLE;
        end else begin
            case (weight_state_q)
                IDLE: begin
                    weight_state_q <= LOAD_WEIGHTS;
                end

                LOAD_WEIGHTS: begin
                    if (tile_done) begin
                        weight_state_q <= DOUBLE_BUFFER;
                    end
                end

                DOUBLE_BUFFER: begin
                    if (next_weight_tile_i) begin
                        // Shadow becomes active and keeps its fill progress
                        if (!tile_done) begin
                            weight_state_q <= LOAD_WEIGHTS;
                        end
                    end else if (tile_done) begin
                        weight_state_q <= FULL;
                    end
                end

                FULL: begin
                    if (next_weight_tile_i) begin
                        weight_state_q <= DOUBLE_BUFFER;   // Old active bank refills as shadow
                    end
                end

                default: begin
                    weight_state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/handshake_fifo.sv
`timescale 1ns/1ps

module handshake_fifo
    import tpu_package::*;
#(
    parameter type T = weight_t
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic req_i,
    input  T     data_i,
    output logic ack_o,
    input  logic pop_i,
    output logic valid_o,
    output T     head_o
);

    T                 mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic do_write;
    logic do_pop;
    logic has_space;

    assign valid_o   = (count_q != '0);
    assign head_o    = mem_q[rd_ptr_q];
    assign do_pop    = pop_i && valid_o;
    assign has_space = (count_q != CNT_W'(FIFO_DEPTH)) || do_pop;  // Pop frees a slot this edge

    // New item only while ack is low, so a held req is taken once
    assign do_write  = req_i && !ack_o && has_space;

    // ========================================
    // Storage
    // ========================================
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // ========================================
    // Four-phase receiver and pointers
    // ========================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o    <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_write) begin
                ack_o <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;         // Sender has dropped req
            end

            if (do_write) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)   rd_ptr_q <= rd_ptr_q + 1'b1;

            count_q <= count_q + CNT_W'(do_write) - CNT_W'(do_pop);
        end
    end

endmodule

// File: source/tpu_package.sv
package tpu_package;

    // ========================================
    // Sizes
    // ========================================
    localparam int MUL_SIZE   = 8;   // Lanes per vector, weights per tile
    localparam int DATA_W     = 8;
    localparam int ACC_W      = 20;  // Holds MUL_SIZE signed 8x8 products
    localparam int FIFO_DEPTH = 4;

    localparam int CNTR_W     = $clog2(MUL_SIZE);
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

    // ========================================
    // Payload types
    // ========================================
    typedef logic signed [DATA_W-1:0] weight_t;

    typedef struct packed {
        logic                             last;   // Retires the active tile
        logic [MUL_SIZE-1:0][DATA_W-1:0]  lanes;
    } act_vec_t;

    // Weight bank sequencing
    typedef enum logic [2:0] {IDLE, LOAD_WEIGHTS, DOUBLE_BUFFER, FULL} weight_state_t;

endpackage
